// ==== rtl/dcache_pkg.sv ====
package dcache_pkg;

  // cache geometry
  localparam int line_words  = 4;
  localparam int num_lines   = 16;
  localparam int offset_bits = 2;
  localparam int index_bits  = 4;
  localparam int tag_bits    = 24;

  typedef logic [31:0] word_t;

  // tag in 31:8, index in 7:4, word offset in 3:2
  typedef logic [31:0] addr_t;

  typedef logic [tag_bits-1:0]    tag_t;
  typedef logic [index_bits-1:0]  index_t;
  typedef logic [offset_bits-1:0] offset_t;
  typedef logic [3:0]             mask_t;

  // 0 byte, 1 halfword, 2 or 3 word
  typedef logic [1:0] size_t;

  typedef enum logic [2:0] {
    idle,
    lookup,
    evict_cmd,
    evict_data,
    fill_cmd,
    fill_data,
    done
  } cache_state_t;

endpackage

// ==== rtl/access_decode.sv ====
module access_decode import dcache_pkg::*; (
  input  logic    clk_core,
  input  logic    reset_n,

  input  logic    req_valid,
  input  logic    req_write,
  input  size_t   req_size,
  input  logic    req_extend,
  input  addr_t   req_addr,
  input  word_t   req_wdata,
  output logic    req_ready,

  input  logic    acc_done,
  input  logic    resp_busy,

  output logic    acc_pending,
  output logic    acc_write,
  output tag_t    acc_tag,
  output index_t  acc_index,
  output offset_t acc_offset,
  output word_t   acc_wdata,
  output mask_t   acc_wmask,
  output size_t   acc_size,
  output logic    acc_extend,
  output logic [1:0] acc_byte
);

  logic  accept;
  word_t lane_wdata;
  mask_t lane_mask;

  // a new access waits for the previous response to drain
  assign req_ready = ~acc_pending & ~resp_busy;
  assign accept    = req_valid & req_ready;

  // place store data into its byte lanes
  always_comb begin
    lane_wdata = '0;
    lane_mask  = '0;
    casez (req_size)
      2'b00: begin
        lane_wdata[req_addr[1:0]*8 +: 8] = req_wdata[7:0];
        lane_mask[req_addr[1:0]]         = 1'b1;
      end
      2'b01: begin
        lane_wdata[req_addr[1]*16 +: 16] = req_wdata[15:0];
        lane_mask[req_addr[1]*2 +: 2]    = 2'b11;
      end
      default: begin
        lane_wdata = req_wdata;
        lane_mask  = '1;
      end
    endcase
  end

  always_ff @(posedge clk_core) begin
    if (!reset_n) begin
      acc_pending <= 1'b0;
    end else if (accept) begin
      acc_pending <= 1'b1;
    end else if (acc_done) begin
      // result now sits in load_result until taken
      acc_pending <= 1'b0;
    end
  end

  always_ff @(posedge clk_core) begin
    if (accept) begin
      acc_write  <= req_write;
      acc_tag    <= req_addr[31:8];
      acc_index  <= req_addr[7:4];
      acc_offset <= req_addr[3:2];
      acc_wdata  <= lane_wdata;
      acc_wmask  <= lane_mask;
      acc_size   <= req_size;
      acc_extend <= req_extend;
      acc_byte   <= req_addr[1:0];
    end
  end

endmodule

// ==== rtl/line_store.sv ====
module line_store import dcache_pkg::*; (
  input  logic    clk_core,
  input  logic    reset_n,

  input  index_t  rd_index,
  input  offset_t rd_offset,
  output tag_t    rd_tag,
  output logic    rd_valid,
  output logic    rd_dirty,
  output word_t   rd_word,

  input  logic    wr_en,
  input  index_t  wr_index,
  input  offset_t wr_offset,
  input  word_t   wr_word,
  input  mask_t   wr_mask,

  input  logic    meta_en,
  input  tag_t    meta_tag,
  input  logic    meta_valid,
  input  logic    meta_dirty
);

  word_t data_mem [num_lines][line_words];
  tag_t  tag_mem [num_lines];

  logic [num_lines-1:0] valid_bits;
  logic [num_lines-1:0] dirty_bits;

  assign rd_tag   = tag_mem[rd_index];
  assign rd_valid = valid_bits[rd_index];
  assign rd_dirty = dirty_bits[rd_index];
  assign rd_word  = data_mem[rd_index][rd_offset];

  // line state, shares the write index
  always_ff @(posedge clk_core) begin
    if (!reset_n) begin
      valid_bits <= '0;
      dirty_bits <= '0;
    end else if (meta_en) begin
      valid_bits[wr_index] <= meta_valid;
      dirty_bits[wr_index] <= meta_dirty;
    end
  end

  always_ff @(posedge clk_core) begin
    if (meta_en) begin
      tag_mem[wr_index] <= meta_tag;
    end
  end

  // byte-lane writes
  always_ff @(posedge clk_core) begin
    if (wr_en) begin
      for (int i = 0; i < $bits(mask_t); i++) begin
        if (wr_mask[i]) begin
          data_mem[wr_index][wr_offset][i*8 +: 8] <= wr_word[i*8 +: 8];
        end
      end
    end
  end

endmodule

// ==== rtl/miss_engine.sv ====
module miss_engine import dcache_pkg::*; (
  input  logic    clk_core,
  input  logic    reset_n,

  input  logic    acc_pending,
  input  logic    acc_write,
  input  tag_t    acc_tag,
  input  index_t  acc_index,
  input  offset_t acc_offset,
  input  word_t   acc_wdata,
  input  mask_t   acc_wmask,
  output logic    acc_done,
  output word_t   hit_word,

  output logic    bus_cvalid,
  input  logic    bus_cready,
  output logic    bus_cmd,
  output addr_t   bus_addr,

  output logic    bus_wvalid,
  input  logic    bus_wready,
  output word_t   bus_wdata,
  output mask_t   bus_wmask,
  output logic    bus_wlast,

  input  logic    bus_rvalid,
  output logic    bus_rready,
  input  word_t   bus_rdata
);

  cache_state_t state, state_next;
  offset_t beat;
  logic    last_beat;
  logic    hit;

  offset_t rd_offset;
  tag_t    rd_tag;
  logic    rd_valid, rd_dirty;
  word_t   rd_word;

  logic    wr_en;
  offset_t wr_offset;
  word_t   wr_word;
  mask_t   wr_mask;
  logic    meta_en, meta_dirty;

  // every line write leaves the line valid
  line_store u_line_store (
    .clk_core   (clk_core),
    .reset_n    (reset_n),
    .rd_index   (acc_index),
    .rd_offset  (rd_offset),
    .rd_tag     (rd_tag),
    .rd_valid   (rd_valid),
    .rd_dirty   (rd_dirty),
    .rd_word    (rd_word),
    .wr_en      (wr_en),
    .wr_index   (acc_index),
    .wr_offset  (wr_offset),
    .wr_word    (wr_word),
    .wr_mask    (wr_mask),
    .meta_en    (meta_en),
    .meta_tag   (acc_tag),
    .meta_valid (1'b1),
    .meta_dirty (meta_dirty)
  );

  assign hit       = rd_valid & (rd_tag == acc_tag);
  assign last_beat = beat == offset_t'(line_words - 1);
  assign rd_offset = (state == evict_data) ? beat : acc_offset;
  assign hit_word  = rd_word;

  always_ff @(posedge clk_core) begin
    if (!reset_n) begin
      state <= idle;
      beat  <= '0;
    end else begin
      state <= state_next;
      if (bus_cvalid & bus_cready) begin
        beat <= '0;
      end else if ((bus_wvalid & bus_wready) | (bus_rready & bus_rvalid)) begin
        beat <= beat + offset_t'(1);
      end
    end
  end

  always_comb begin
    state_next = state;
    acc_done   = 1'b0;
    bus_cvalid = 1'b0;
    bus_cmd    = 1'b0;
    bus_addr   = '0;
    bus_wvalid = 1'b0;
    bus_wdata  = '0;
    bus_wmask  = '0;
    bus_wlast  = 1'b0;
    bus_rready = 1'b0;
    wr_en      = 1'b0;
    wr_offset  = acc_offset;
    wr_word    = acc_wdata;
    wr_mask    = acc_wmask;
    meta_en    = 1'b0;
    meta_dirty = 1'b0;

    case (state)
      idle: begin
        if (acc_pending) begin
          state_next = lookup;
        end
      end
      lookup: begin
        if (hit) begin
          state_next = done;
        end else if (rd_valid & rd_dirty) begin
          state_next = evict_cmd;
        end else begin
          state_next = fill_cmd;
        end
      end
      evict_cmd: begin
        // old line address comes from the stored tag
        bus_cvalid = 1'b1;
        bus_addr   = {rd_tag, acc_index, 4'b0000};
        if (bus_cready) begin
          state_next = evict_data;
        end
      end
      evict_data: begin
        bus_wvalid = 1'b1;
        bus_wdata  = rd_word;
        bus_wmask  = '1;
        bus_wlast  = last_beat;
        if (bus_wready & last_beat) begin
          state_next = fill_cmd;
        end
      end
      fill_cmd: begin
        bus_cvalid = 1'b1;
        bus_cmd    = 1'b1;
        bus_addr   = {acc_tag, acc_index, 4'b0000};
        if (bus_cready) begin
          state_next = fill_data;
        end
      end
      fill_data: begin
        bus_rready = 1'b1;
        wr_en      = bus_rvalid;
        wr_offset  = beat;
        wr_word    = bus_rdata;
        wr_mask    = '1;
        // tag switches only once the whole line is in
        if (bus_rvalid & last_beat) begin
          meta_en    = 1'b1;
          state_next = lookup;
        end
      end
      done: begin
        acc_done   = 1'b1;
        wr_en      = acc_write;
        meta_en    = acc_write;
        meta_dirty = 1'b1;
        state_next = idle;
      end
      default: begin
        state_next = idle;
      end
    endcase
  end

endmodule

// ==== rtl/load_result.sv ====
module load_result import dcache_pkg::*; (
  input  logic  clk_core,
  input  logic  reset_n,

  input  logic  acc_done,
  input  word_t hit_word,
  input  logic  acc_write,
  input  size_t acc_size,
  input  logic  acc_extend,
  input  logic [1:0] acc_byte,

  input  logic  resp_ready,
  output logic  resp_valid,
  output word_t resp_data,
  output logic  resp_busy
);

  word_t load_word;

  // align and extend
  always_comb begin
    casez (acc_size)
      2'b00: begin
        load_word[7:0]  = hit_word[acc_byte*8 +: 8];
        load_word[31:8] = acc_extend ? {24{load_word[7]}} : 24'd0;
      end
      2'b01: begin
        load_word[15:0]  = hit_word[acc_byte[1]*16 +: 16];
        load_word[31:16] = acc_extend ? {16{load_word[15]}} : 16'd0;
      end
      default: begin
        load_word = hit_word;
      end
    endcase
  end

  always_ff @(posedge clk_core) begin
    if (!reset_n) begin
      resp_valid <= 1'b0;
    end else if (acc_done) begin
      resp_valid <= 1'b1;
    end else if (resp_ready) begin
      resp_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk_core) begin
    if (acc_done) begin
      resp_data <= acc_write ? word_t'(0) : load_word;
    end
  end

  assign resp_busy = resp_valid;

endmodule

// ==== rtl/dcache_stage.sv ====
module dcache_stage import dcache_pkg::*; (
  input  logic  clk_core,
  input  logic  reset_n,

  input  logic  req_valid,
  output logic  req_ready,
  input  logic  req_write,
  input  size_t req_size,
  input  logic  req_extend,
  input  addr_t req_addr,
  input  word_t req_wdata,

  output logic  resp_valid,
  input  logic  resp_ready,
  output word_t resp_data,

  output logic  bus_cvalid,
  input  logic  bus_cready,
  output logic  bus_cmd,
  output addr_t bus_addr,

  output logic  bus_wvalid,
  input  logic  bus_wready,
  output word_t bus_wdata,
  output mask_t bus_wmask,
  output logic  bus_wlast,

  input  logic  bus_rvalid,
  output logic  bus_rready,
  input  word_t bus_rdata
);

  logic    acc_pending, acc_write, acc_extend, acc_done, resp_busy;
  tag_t    acc_tag;
  index_t  acc_index;
  offset_t acc_offset;
  word_t   acc_wdata, hit_word;
  mask_t   acc_wmask;
  size_t   acc_size;
  logic [1:0] acc_byte;

  access_decode u_decode (
    .clk_core    (clk_core),
    .reset_n     (reset_n),
    .req_valid   (req_valid),
    .req_write   (req_write),
    .req_size    (req_size),
    .req_extend  (req_extend),
    .req_addr    (req_addr),
    .req_wdata   (req_wdata),
    .req_ready   (req_ready),
    .acc_done    (acc_done),
    .resp_busy   (resp_busy),
    .acc_pending (acc_pending),
    .acc_write   (acc_write),
    .acc_tag     (acc_tag),
    .acc_index   (acc_index),
    .acc_offset  (acc_offset),
    .acc_wdata   (acc_wdata),
    .acc_wmask   (acc_wmask),
    .acc_size    (acc_size),
    .acc_extend  (acc_extend),
    .acc_byte    (acc_byte)
  );

  miss_engine u_engine (
    .clk_core    (clk_core),
    .reset_n     (reset_n),
    .acc_pending (acc_pending),
    .acc_write   (acc_write),
    .acc_tag     (acc_tag),
    .acc_index   (acc_index),
    .acc_offset  (acc_offset),
    .acc_wdata   (acc_wdata),
    .acc_wmask   (acc_wmask),
    .acc_done    (acc_done),
    .hit_word    (hit_word),
    .bus_cvalid  (bus_cvalid),
    .bus_cready  (bus_cready),
    .bus_cmd     (bus_cmd),
    .bus_addr    (bus_addr),
    .bus_wvalid  (bus_wvalid),
    .bus_wready  (bus_wready),
    .bus_wdata   (bus_wdata),
    .bus_wmask   (bus_wmask),
    .bus_wlast   (bus_wlast),
    .bus_rvalid  (bus_rvalid),
    .bus_rready  (bus_rready),
    .bus_rdata   (bus_rdata)
  );

  load_result u_result (
    .clk_core    (clk_core),
    .reset_n     (reset_n),
    .acc_done    (acc_done),
    .hit_word    (hit_word),
    .acc_write   (acc_write),
    .acc_size    (acc_size),
    .acc_extend  (acc_extend),
    .acc_byte    (acc_byte),
    .resp_ready  (resp_ready),
    .resp_valid  (resp_valid),
    .resp_data   (resp_data),
    .resp_busy   (resp_busy)
  );

endmodule

// ==== tests/tb_dcache_stage.sv ====
module tb_dcache_stage import dcache_pkg::*; ();

  localparam int    wait_limit = 200;
  localparam int    idle_limit = 5000;
  localparam addr_t base_a     = 32'h1234_5670;

  logic  clk_core;
  logic  reset_n;
  logic  req_valid, req_ready, req_write, req_extend;
  size_t req_size;
  addr_t req_addr;
  word_t req_wdata;
  logic  resp_valid, resp_ready;
  word_t resp_data;
  logic  bus_cvalid, bus_cready, bus_cmd;
  addr_t bus_addr;
  logic  bus_wvalid, bus_wready, bus_wlast;
  word_t bus_wdata;
  mask_t bus_wmask;
  logic  bus_rvalid, bus_rready;
  word_t bus_rdata;

  // word contents keyed by word-aligned byte address
  word_t shadow [addr_t];
  word_t bus_mem [addr_t];

  int    req_count = 0;
  int    resp_count = 0;
  int    stall_pct = 0;
  int    rd_cmds = 0;
  int    wr_cmds = 0;
  int    cmd_seq = 0;
  int    rd_seq = 0;
  int    wr_seq = 0;
  addr_t last_rd_addr, last_wr_addr;

  dcache_stage uut (.*);

  always #2 clk_core = ~clk_core;

  always @(posedge clk_core) begin
    if (reset_n && resp_valid && resp_ready) begin
      resp_count++;
    end
  end

  task automatic abort_run(input string why);
    $display("TB FAILED");
    $fatal(1, "%s", why);
  endtask

  task automatic timed_out(input string what);
    $display("TB FAILED");
    $fatal(1, "timeout waiting for %s", what);
  endtask

  task automatic report_mismatch(input string test, input word_t expected, input word_t actual);
    $display("Fail %s: expected %h, actual %h", test, expected, actual);
    abort_run("value mismatch");
  endtask

  task automatic check_value(input string test, input word_t expected, input word_t actual);
    assert (actual === expected) else report_mismatch(test, expected, actual);
  endtask

  assert property (@(posedge clk_core) disable iff (!reset_n)
    resp_valid && !resp_ready |=> resp_valid && $stable(resp_data))
    else abort_run("response changed before it was taken");
  assert property (@(posedge clk_core) disable iff (!reset_n)
    bus_cvalid && !bus_cready |=> bus_cvalid && $stable(bus_addr) && $stable(bus_cmd))
    else abort_run("bus command changed before it was accepted");
  assert property (@(posedge clk_core) disable iff (!reset_n)
    bus_wvalid && !bus_wready |=> bus_wvalid && $stable(bus_wdata) && $stable(bus_wlast))
    else abort_run("bus write beat changed before it was accepted");
  assert property (@(posedge clk_core) disable iff (!reset_n)
    bus_cvalid |-> bus_addr[3:0] == 4'h0)
    else abort_run("bus command address is not line aligned");
  assert property (@(posedge clk_core) disable iff (!reset_n)
    bus_wvalid |-> bus_wmask == 4'hf)
    else abort_run("write burst beat without a full byte mask");
  assert property (@(posedge clk_core) disable iff (!reset_n)
    resp_valid |-> !req_ready)
    else abort_run("request port open while a response is waiting");

  // contents of untouched memory
  function automatic word_t fill_word(input addr_t a);
    return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
  endfunction

  function automatic word_t shadow_word(input addr_t a);
    addr_t wa;
    wa = {a[31:2], 2'b00};
    return shadow.exists(wa) ? shadow[wa] : fill_word(wa);
  endfunction

  function automatic word_t mem_word(input addr_t a);
    return bus_mem.exists(a) ? bus_mem[a] : fill_word(a);
  endfunction

  function automatic word_t expected_result(input logic wr, input size_t sz, input logic ext,
                                            input addr_t a);
    word_t       w;
    logic [7:0]  b;
    logic [15:0] h;
    w = shadow_word(a);
    b = w[8*a[1:0] +: 8];
    h = w[16*a[1] +: 16];
    if (wr) return '0;
    if (sz == 2'd0) return ext ? {{24{b[7]}}, b} : {24'h0, b};
    if (sz == 2'd1) return ext ? {{16{h[15]}}, h} : {16'h0, h};
    return w;
  endfunction

  function automatic void store_shadow(input size_t sz, input addr_t a, input word_t d);
    word_t w;
    w = shadow_word(a);
    if (sz == 2'd0) begin
      w[8*a[1:0] +: 8] = d[7:0];
    end else if (sz == 2'd1) begin
      w[16*a[1] +: 16] = d[15:0];
    end else begin
      w = d;
    end
    shadow[{a[31:2], 2'b00}] = w;
  endfunction

  task automatic take_command(output addr_t addr, output logic is_read);
    int   n;
    logic seen;
    n = 0;
    seen = 1'b0;
    while (!seen) begin
      @(posedge clk_core);
      if (bus_cvalid && bus_cready) begin
        seen = 1'b1;
        addr = bus_addr;
        is_read = bus_cmd;
      end
      #1 bus_cready = ($urandom % 3) != 0;
      n++;
      if (!seen && n > idle_limit) timed_out("a bus command");
    end
    cmd_seq++;
    if (is_read) begin
      rd_cmds++;
      last_rd_addr = addr;
      rd_seq = cmd_seq;
    end else begin
      wr_cmds++;
      last_wr_addr = addr;
      wr_seq = cmd_seq;
    end
  endtask

  task automatic read_burst(input addr_t base);
    int   n;
    logic seen;
    for (int k = 0; k < line_words; k++) begin
      bus_rdata = mem_word(base + 4 * k);
      bus_rvalid = ($urandom % 2) == 0;
      n = 0;
      seen = 1'b0;
      while (!seen) begin
        @(posedge clk_core);
        seen = bus_rvalid && bus_rready;
        #1;
        if (!bus_rvalid) bus_rvalid = ($urandom % 2) == 0;
        n++;
        if (!seen && n > wait_limit) timed_out("a read beat");
      end
      bus_rvalid = 1'b0;
    end
  endtask

  task automatic write_burst(input addr_t base);
    int   n;
    logic seen;
    for (int k = 0; k < line_words; k++) begin
      n = 0;
      seen = 1'b0;
      while (!seen) begin
        @(posedge clk_core);
        if (bus_wvalid && bus_wready) begin
          seen = 1'b1;
          check_value("evict wlast", word_t'(k == line_words - 1), word_t'(bus_wlast));
          check_value("evict data", shadow_word(base + 4 * k), bus_wdata);
          bus_mem[base + 4 * k] = bus_wdata;
        end
        #1 bus_wready = ($urandom % 3) != 0;
        n++;
        if (!seen && n > wait_limit) timed_out("a write beat");
      end
    end
  endtask

  // bus memory serves one burst at a time
  initial begin : bus_model
    addr_t addr;
    logic  is_read;
    forever begin
      take_command(addr, is_read);
      if (is_read) begin
        read_burst(addr);
      end else begin
        write_burst(addr);
      end
    end
  end

  task automatic do_access(input string test, input logic wr, input size_t sz, input logic ext,
                           input addr_t a, input word_t wdata);
    word_t expected;
    int    n;
    logic  seen;
    req_valid = 1'b1;
    req_write = wr;
    req_size = sz;
    req_extend = ext;
    req_addr = a;
    req_wdata = wdata;
    n = 0;
    seen = 1'b0;
    while (!seen) begin
      @(posedge clk_core);
      seen = req_ready;
      #1;
      n++;
      if (!seen && n > wait_limit) timed_out("req_ready");
    end
    req_valid = 1'b0;
    expected = expected_result(wr, sz, ext, a);
    if (wr) store_shadow(sz, a, wdata);
    req_count++;
    n = 0;
    seen = 1'b0;
    resp_ready = ($urandom % 100) >= stall_pct;
    while (!seen) begin
      @(posedge clk_core);
      if (resp_valid && resp_ready) begin
        seen = 1'b1;
        check_value(test, expected, resp_data);
      end
      #1 resp_ready = ($urandom % 100) >= stall_pct;
      n++;
      if (!seen && n > wait_limit) timed_out("a response");
    end
  endtask

  initial begin
    int    cmds_before;
    addr_t far_b;
    size_t sz;
    addr_t a;
    void'($urandom(32'he0a4_6748));
    clk_core = 1'b0;
    reset_n = 1'b0;
    req_valid = 1'b0;
    req_write = 1'b0;
    req_size = '0;
    req_extend = 1'b0;
    req_addr = '0;
    req_wdata = '0;
    resp_ready = 1'b0;
    bus_cready = 1'b0;
    bus_wready = 1'b0;
    bus_rvalid = 1'b0;
    bus_rdata = '0;
    repeat (2) @(posedge clk_core);
    #1 reset_n = 1'b1;

    check_value("reset req_ready", 1, word_t'(req_ready));
    check_value("reset resp_valid", 0, word_t'(resp_valid));
    check_value("reset bus_cvalid", 0, word_t'(bus_cvalid));
    check_value("reset bus_wvalid", 0, word_t'(bus_wvalid));
    check_value("reset bus_rready", 0, word_t'(bus_rready));

    // a single refill serves the whole cold line
    do_access("load word cold", 1'b0, 2'd2, 1'b0, base_a + 4, '0);
    check_value("cold read commands", 1, rd_cmds);
    check_value("cold read address", base_a, last_rd_addr);
    do_access("load byte sext", 1'b0, 2'd0, 1'b1, base_a + 5, '0);
    do_access("load byte zext", 1'b0, 2'd0, 1'b0, base_a + 7, '0);
    do_access("load half sext", 1'b0, 2'd1, 1'b1, base_a + 10, '0);
    do_access("load half zext", 1'b0, 2'd1, 1'b0, base_a + 12, '0);
    check_value("one read command per line", 1, rd_cmds);

    // store merges on a resident line
    cmds_before = rd_cmds + wr_cmds;
    for (int k = 0; k < 4; k++) begin
      do_access("store byte", 1'b1, 2'd0, 1'b0, base_a + k, $urandom);
      do_access("load byte", 1'b0, 2'd0, k[0], base_a + k, '0);
      do_access("load merged word", 1'b0, 2'd2, 1'b0, base_a, '0);
    end
    for (int k = 0; k < 4; k += 2) begin
      do_access("store half", 1'b1, 2'd1, 1'b0, base_a + 8 + k, $urandom);
      do_access("load half", 1'b0, 2'd1, k[1], base_a + 8 + k, '0);
      do_access("load merged word", 1'b0, 2'd3, 1'b0, base_a + 8, '0);
    end
    do_access("store word", 1'b1, 2'd2, 1'b0, base_a + 12, $urandom);
    do_access("load word", 1'b0, 2'd2, 1'b0, base_a + 12, '0);
    check_value("bus commands on hits", cmds_before, rd_cmds + wr_cmds);

    // same index with another tag
    far_b = base_a ^ 32'h0100_0000;
    do_access("conflict load", 1'b0, 2'd2, 1'b0, far_b, '0);
    check_value("evict commands", 1, wr_cmds);
    check_value("evict address", base_a, last_wr_addr);
    check_value("fill address", far_b, last_rd_addr);
    check_value("fill after evict", wr_seq + 1, rd_seq);
    do_access("reload written back", 1'b0, 2'd2, 1'b0, base_a + 4, '0);

    // 4 tags over all indices keeps conflicts frequent
    stall_pct = 30;
    for (int i = 0; i < 400; i++) begin
      sz = size_t'($urandom % 4);
      a = {8'h40, 14'h0, 10'($urandom)};
      if (sz == 2'd1) begin
        a[0] = 1'b0;
      end else if (sz[1]) begin
        a[1:0] = 2'b00;
      end
      do_access("random mix", 1'($urandom), sz, 1'($urandom), a, $urandom);
    end

    if (resp_count !== req_count) begin
      report_mismatch("response count", req_count, resp_count);
    end else begin
      $display("TB PASSED");
      $finish;
    end
  end

endmodule

// ==== dcache_stage.f ====
rtl/dcache_pkg.sv
rtl/access_decode.sv
rtl/line_store.sv
rtl/miss_engine.sv
rtl/load_result.sv
rtl/dcache_stage.sv
tests/tb_dcache_stage.sv

// ==== Makefile ====
.PHONY: all lint clean

all: obj_dir/Vtb_dcache_stage
	./obj_dir/Vtb_dcache_stage

obj_dir/Vtb_dcache_stage: dcache_stage.f rtl/*.sv tests/*.sv
	verilator --binary --timing --assert -f dcache_stage.f --top-module tb_dcache_stage

lint:
	verilator --lint-only --timing --assert -f dcache_stage.f --top-module tb_dcache_stage
	verilator --lint-only rtl/dcache_pkg.sv rtl/access_decode.sv rtl/line_store.sv \
	  rtl/miss_engine.sv rtl/load_result.sv rtl/dcache_stage.sv --top-module dcache_stage

clean:
	rm -rf obj_dir
